// ==== hdl/comms_config.svh ====
`ifndef COMMS_CONFIG_SVH
`define COMMS_CONFIG_SVH

// clocks per serial bit on the link
`define COMMS_BIT_CYCLES 8

// roster slots, one per player id
`define COMMS_NUM_PLAYERS 4

// payload bits in one frame, between start and stop bit
`define COMMS_PACKET_BITS 32

`endif

// ==== hdl/comms_pkg.sv ====
`default_nettype none

`include "comms_config.svh"

package comms_pkg;

    typedef logic [1:0] player_id_t;

    typedef logic [2:0] game_state_t; // game phase, only player 0 is authoritative

    typedef struct packed {
        logic [1:0] direction;
        logic [8:0] loc_x;
        logic [8:0] loc_y;
        logic [3:0] state;
    } player_info_t;

    // low 3 bits of every packet
    typedef enum logic [2:0] {
        PTYPE_PSTATE = 3'b000,
        PTYPE_ACK    = 3'b111
    } ptype_e;

    // 32 bit packet, player in the top bits, type in the bottom bits
    typedef struct packed {
        player_id_t   player;
        player_info_t info;
        game_state_t  game_state; // zero unless sent by player 0
        ptype_e       ptype;
    } packet_t;

    // slot index is the player id
    typedef player_info_t [`COMMS_NUM_PLAYERS-1:0] roster_t;

endpackage

`default_nettype wire

// ==== hdl/serial_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "comms_config.svh"

module serial_rx import comms_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  wire     line_in,
    output logic    rx_valid,
    output packet_t rx_packet
);

    localparam int BIT_CYCLES = `COMMS_BIT_CYCLES;
    localparam int PKT_BITS   = `COMMS_PACKET_BITS;
    localparam int CNT_W      = $clog2(BIT_CYCLES);
    localparam int BIT_W      = $clog2(PKT_BITS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(BIT_CYCLES / 2 - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(PKT_BITS - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e           state;
    logic                line_meta;
    logic                line_sync;
    logic                line_prev;
    logic [CNT_W-1:0]    cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic [PKT_BITS-1:0] shift_reg;

    // two-flop synchroniser, third flop for the falling edge
    always_ff @(posedge clk) begin
        if (rst) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            line_meta <= line_in;
            line_sync <= line_meta;
            line_prev <= line_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    if (line_prev && !line_sync)
                        state <= RX_START;
                end
                RX_START: begin
                    if (cnt == CNT_HALF) begin
                        cnt   <= '0;
                        state <= line_sync ? RX_IDLE : RX_DATA; // high at mid-bit is a glitch
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == CNT_LAST) begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST)
                            state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == CNT_LAST) begin
                        rx_valid <= line_sync; // low stop bit drops the frame
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data arrives lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == CNT_LAST)
            shift_reg <= {line_sync, shift_reg[PKT_BITS-1:1]};
        if (state == RX_STOP && cnt == CNT_LAST && line_sync)
            rx_packet <= packet_t'(shift_reg);
    end

endmodule

`default_nettype wire

// ==== hdl/roster_update.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "comms_config.svh"

module roster_update import comms_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          player_id_t player_id,
    input  wire          player_info_t local_info,
    input  wire          rx_valid,
    input  wire          packet_t rx_packet,
    output roster_t      roster,
    output game_state_t  game_state_out
);

    logic rx_pstate;
    logic rx_from_main;

    // remote player state, never our own id
    assign rx_pstate = rx_valid && (rx_packet.ptype == PTYPE_PSTATE)
                       && (rx_packet.player != player_id);

    // game state is only trusted from player 0
    assign rx_from_main = rx_pstate && (rx_packet.player == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            roster         <= '0;
            game_state_out <= '0;
        end else begin
            for (int i = 0; i < `COMMS_NUM_PLAYERS; i++) begin
                if (player_id_t'(i) == player_id) begin
                    roster[i] <= local_info; // own slot mirrors local inputs
                end else if (rx_pstate && rx_packet.player == player_id_t'(i)) begin
                    roster[i] <= rx_packet.info;
                end
            end
            if (rx_from_main)
                game_state_out <= rx_packet.game_state;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/state_tx_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module state_tx_ctrl import comms_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  wire     player_id_t player_id,
    input  wire     player_info_t local_info,
    input  wire     game_state_t local_game_state,
    input  wire     rx_valid,
    input  wire     packet_t rx_packet,
    input  wire     tx_ack,
    output logic    tx_req,
    output packet_t tx_packet
);

    typedef enum logic [1:0] {
        ST_IDLE     = 2'b00,
        ST_REQ      = 2'b01,
        ST_RELEASE  = 2'b10,
        ST_WAIT_ACK = 2'b11
    } ctrl_state_e;

    ctrl_state_e state;
    packet_t     local_packet;
    packet_t     last_sent;
    logic        is_main;

    assign is_main = (player_id == '0);

    always_comb begin
        local_packet.player     = player_id;
        local_packet.info       = local_info;
        local_packet.game_state = is_main ? local_game_state : '0;
        local_packet.ptype      = PTYPE_PSTATE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            tx_req    <= 1'b0;
            last_sent <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // the main node does not report its state this way
                    if (!is_main && local_packet != last_sent) begin
                        last_sent <= local_packet;
                        tx_req    <= 1'b1;
                        state     <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state  <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!tx_ack)
                        state <= ST_WAIT_ACK;
                end
                ST_WAIT_ACK: begin
                    if (rx_valid && rx_packet.ptype == PTYPE_ACK)
                        state <= ST_IDLE; // peer has the packet
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // held stable through the whole req/ack exchange
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && !is_main && local_packet != last_sent)
            tx_packet <= local_packet;
    end

endmodule

`default_nettype wire

// ==== hdl/serial_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "comms_config.svh"

module serial_tx import comms_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  tx_req,
    input  wire  packet_t tx_packet,
    output logic tx_ack,
    output logic line_out
);

    localparam int BIT_CYCLES = `COMMS_BIT_CYCLES;
    localparam int PKT_BITS   = `COMMS_PACKET_BITS;
    localparam int CNT_W      = $clog2(BIT_CYCLES);
    localparam int FRM_W      = $clog2(PKT_BITS + 2);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_CYCLES - 1);
    localparam logic [FRM_W-1:0] FRM_LAST = FRM_W'(PKT_BITS + 1); // index of the stop bit

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_ACK} tx_state_e;

    tx_state_e         state;
    logic [CNT_W-1:0]  cnt;
    logic [FRM_W-1:0]  bit_cnt;
    logic [PKT_BITS:0] data_sr; // stop bit above the payload

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            bit_cnt  <= '0;
            tx_ack   <= 1'b0;
            line_out <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    // ack is already low here, so a high req is a new request
                    if (tx_req) begin
                        line_out <= 1'b0; // start bit
                        state    <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (cnt == CNT_LAST) begin
                        cnt <= '0;
                        if (bit_cnt == FRM_LAST) begin
                            line_out <= 1'b1;
                            state    <= TX_ACK;
                        end else begin
                            line_out <= data_sr[0];
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_ACK: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= TX_IDLE;
                    end else begin
                        tx_ack <= 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // payload latched at the request, shifted out lsb first
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_req)
            data_sr <= {1'b1, tx_packet};
        else if (state == TX_SEND && cnt == CNT_LAST)
            data_sr <= {1'b1, data_sr[PKT_BITS:1]};
    end

endmodule

`default_nettype wire

// ==== hdl/comms_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module comms_top import comms_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          player_id_t player_id,
    input  wire          player_info_t local_info,
    input  wire          game_state_t local_game_state,
    input  wire          line_in,
    output logic         line_out,
    output roster_t      roster,
    output game_state_t  game_state_out
);

    logic    rx_valid;
    packet_t rx_packet;
    logic    tx_req;
    logic    tx_ack;
    packet_t tx_packet;

    serial_rx u_serial_rx (
        .clk       (clk),
        .rst       (rst),
        .line_in   (line_in),
        .rx_valid  (rx_valid),
        .rx_packet (rx_packet)
    );

    roster_update u_roster_update (
        .clk            (clk),
        .rst            (rst),
        .player_id      (player_id),
        .local_info     (local_info),
        .rx_valid       (rx_valid),
        .rx_packet      (rx_packet),
        .roster         (roster),
        .game_state_out (game_state_out)
    );

    // also watches the receive side for the ACK
    state_tx_ctrl u_state_tx_ctrl (
        .clk              (clk),
        .rst              (rst),
        .player_id        (player_id),
        .local_info       (local_info),
        .local_game_state (local_game_state),
        .rx_valid         (rx_valid),
        .rx_packet        (rx_packet),
        .tx_ack           (tx_ack),
        .tx_req           (tx_req),
        .tx_packet        (tx_packet)
    );

    serial_tx u_serial_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx_packet (tx_packet),
        .tx_ack    (tx_ack),
        .line_out  (line_out)
    );

endmodule

`default_nettype wire

// ==== sim/comms_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "comms_config.svh"

module comms_tb import comms_pkg::*; ();

    localparam int BIT_CYCLES = `COMMS_BIT_CYCLES;
    localparam int QUIET_WAIT = 40 * BIT_CYCLES; // window in which no frame may start

    logic         clk;
    logic         rst;
    player_id_t   player_id;
    player_info_t local_info;
    game_state_t  local_game_state;
    logic         line_in;
    logic         line_out;
    roster_t      roster;
    game_state_t  game_state_out;

    logic [31:0] rng_state;
    int          rx_count;
    int          err_count;
    int          check_count;
    int          test_errors;

    comms_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .player_id        (player_id),
        .local_info       (local_info),
        .local_game_state (local_game_state),
        .line_in          (line_in),
        .line_out         (line_out),
        .roster           (roster),
        .game_state_out   (game_state_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // counts decoded frames for the tests to wait on
    always @(posedge clk) begin
        if (dut0.rx_valid === 1'b1)
            rx_count <= rx_count + 1;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic player_info_t rand_info();
        logic [31:0] r;
        r = next_rand();
        return player_info_t'(r[23:0]);
    endfunction

    function automatic packet_t make_packet(player_id_t player, player_info_t info,
                                            game_state_t gs, ptype_e ptype);
        packet_t p;
        p.player     = player;
        p.info       = info;
        p.game_state = gs;
        p.ptype      = ptype;
        return p;
    endfunction

    task automatic report_fail(string what);
        $display("%s", what);
        err_count++;
    endtask

    task automatic check_line(string name, logic got, logic exp);
        check_count++;
        if (got !== exp)
            report_fail($sformatf("** Error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_packet(string name, packet_t got, packet_t exp);
        check_count++;
        if (got !== exp)
            report_fail($sformatf("** Error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_info(string name, player_info_t got, player_info_t exp);
        check_count++;
        if (got !== exp)
            report_fail($sformatf("** Error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_game_state(string name, game_state_t got, game_state_t exp);
        check_count++;
        if (got !== exp)
            report_fail($sformatf("** Error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic drive_bit(logic b);
        line_in = b;
        repeat (BIT_CYCLES) @(negedge clk);
    endtask

    task automatic send_frame(packet_t p);
        @(negedge clk);
        drive_bit(1'b0); // start bit
        for (int i = 0; i < `COMMS_PACKET_BITS; i++)
            drive_bit(p[i]);
        drive_bit(1'b1);
    endtask

    task automatic send_and_wait(packet_t p);
        int start;
        int n;
        start = rx_count;
        send_frame(p);
        n = 0;
        while (rx_count == start && n < 4 * BIT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (rx_count == start)
            report_fail("no receive pulse after a frame on line_in");
    endtask

    // samples line_out mid-bit and leaves found low if no start bit shows up in time
    task automatic get_frame(input int max_cycles, output bit found, output packet_t p);
        int n;
        found = 1'b0;
        p = '0;
        n = 0;
        while (line_out !== 1'b0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (line_out !== 1'b0)
            return;
        found = 1'b1;
        repeat (BIT_CYCLES / 2) @(negedge clk);
        if (line_out !== 1'b0)
            report_fail("start bit on line_out ended early");
        for (int i = 0; i < `COMMS_PACKET_BITS; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            p[i] = line_out;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (line_out !== 1'b1)
            report_fail("stop bit on line_out is low");
    endtask

    task automatic expect_frame(packet_t exp);
        bit      found;
        packet_t p;
        get_frame(QUIET_WAIT, found, p);
        if (!found)
            report_fail("timeout waiting for a frame on line_out");
        else
            check_packet("line_out frame", p, exp);
    endtask

    task automatic expect_quiet();
        bit      found;
        packet_t p;
        get_frame(QUIET_WAIT, found, p);
        if (found)
            report_fail("unexpected frame on line_out");
    endtask

    task automatic apply_reset(player_id_t id);
        @(negedge clk);
        rst       = 1'b1;
        player_id = id;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic end_test(string name);
        if (err_count == test_errors)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, err_count - test_errors);
    endtask

    task automatic test_reset_state();
        test_errors = err_count;
        apply_reset(2'd0);
        check_line("line_out", line_out, 1'b1);
        for (int i = 1; i < `COMMS_NUM_PLAYERS; i++)
            check_info($sformatf("roster[%0d]", i), roster[i], '0);
        check_game_state("game_state_out", game_state_out, '0);
        expect_quiet();
        end_test("reset_state");
    endtask

    task automatic test_main_no_tx();
        player_info_t info;
        test_errors = err_count;
        info = rand_info();
        @(negedge clk);
        local_info = info;
        @(negedge clk);
        check_info("roster[0]", roster[0], info);
        expect_quiet(); // main node never reports its own state
        check_info("roster[0]", roster[0], info);
        end_test("main_no_tx");
    endtask

    task automatic test_roster_fill();
        player_info_t info_a;
        test_errors = err_count;
        local_info = rand_info();
        apply_reset(2'd1);
        info_a = rand_info();
        send_and_wait(make_packet(2'd2, info_a, '0, PTYPE_PSTATE));
        check_info("roster[2]", roster[2], info_a);
        send_and_wait(make_packet(2'd1, rand_info(), '0, PTYPE_PSTATE));
        check_info("roster[1]", roster[1], local_info);
        send_and_wait(make_packet(2'd2, rand_info(), '0, ptype_e'(3'b010)));
        check_info("roster[2]", roster[2], info_a);
        check_info("roster[3]", roster[3], '0);
        end_test("roster_fill");
    endtask

    task automatic test_game_state();
        player_info_t info;
        test_errors = err_count;
        info = rand_info();
        send_and_wait(make_packet(2'd0, info, 3'd5, PTYPE_PSTATE));
        check_game_state("game_state_out", game_state_out, 3'd5);
        check_info("roster[0]", roster[0], info);
        info = rand_info();
        send_and_wait(make_packet(2'd3, info, 3'd2, PTYPE_PSTATE));
        check_game_state("game_state_out", game_state_out, 3'd5);
        check_info("roster[3]", roster[3], info);
        end_test("game_state");
    endtask

    task automatic test_state_tx();
        packet_t      ack;
        player_info_t info;
        test_errors = err_count;
        ack  = make_packet(2'd0, '0, '0, PTYPE_ACK);
        info = rand_info();
        local_info = info;
        apply_reset(2'd1);
        expect_frame(make_packet(2'd1, info, '0, PTYPE_PSTATE)); // differs from cleared last-sent
        send_and_wait(ack);
        info = rand_info();
        local_info = info;
        expect_frame(make_packet(2'd1, info, '0, PTYPE_PSTATE));
        info = rand_info();
        local_info       = info;
        local_game_state = 3'd6; // secondary never sends game state
        expect_quiet();
        send_and_wait(ack);
        expect_frame(make_packet(2'd1, info, '0, PTYPE_PSTATE));
        send_and_wait(ack);
        end_test("state_tx");
    endtask

    initial begin
        rst              = 1'b1;
        player_id        = '0;
        local_info       = '0;
        local_game_state = '0;
        line_in          = 1'b1;
        rng_state        = 32'd29;
        err_count        = 0;
        check_count      = 0;
        test_reset_state();
        test_main_no_tx();
        test_roster_fill();
        test_game_state();
        test_state_tx();
        $display("tests 5, checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/comms_pkg.sv
hdl/serial_rx.sv
hdl/roster_update.sv
hdl/state_tx_ctrl.sv
hdl/serial_tx.sv
hdl/comms_top.sv
sim/comms_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= comms_tb
RTL_TOP   ?= comms_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
RTL_SRCS  ?= hdl/comms_pkg.sv hdl/serial_rx.sv hdl/roster_update.sv \
             hdl/state_tx_ctrl.sv hdl/serial_tx.sv hdl/comms_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with $$status"; exit 1; fi
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall +incdir+hdl $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
